// ==== design/rob_defines.svh ====
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// number of storage cells
`define ROB_CELLS      16

// flit field widths
`define ROB_PAYLOAD_W  128
`define ROB_SRC_W      5
`define ROB_QOS_W      2

// order count wide enough for a full buffer
`define ROB_SEQ_W      5

`endif

// ==== design/rob_pkg.sv ====
`include "rob_defines.svh"

package rob_pkg;

    // flit id as seen by the ordering logic
    // port bit keeps ids from A and B apart
    typedef struct packed {
        logic                  port;
        logic [`ROB_SRC_W-1:0] src;
    } flit_id_fields_t;

    // same word read either as one compare key or as its fields
    typedef union packed {
        logic [`ROB_SRC_W:0] raw;
        flit_id_fields_t     fields;
    } flit_id_u;

endpackage

// ==== design/slot_allocator.sv ====
`include "rob_defines.svh"

module slot_allocator (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`ROB_CELLS-1:0] i_cell_valid,
    input  logic [`ROB_CELLS-1:0] i_match_a,
    input  logic [`ROB_CELLS-1:0] i_match_b,
    input  logic                  i_accept_a,
    input  logic                  i_accept_b,
    output logic                  o_ready_a,
    output logic                  o_ready_b,
    output logic [`ROB_CELLS-1:0] o_load_a,
    output logic [`ROB_CELLS-1:0] o_load_b,
    output logic [`ROB_SEQ_W-1:0] o_seq_a,
    output logic [`ROB_SEQ_W-1:0] o_seq_b
);

    logic [`ROB_CELLS-1:0] free;
    logic [`ROB_CELLS-1:0] low_free;
    logic [`ROB_CELLS-1:0] high_free;
    logic [`ROB_SEQ_W-1:0] free_cnt;
    logic                  one_free;
    logic                  many_free;
    // 0 gives the last cell to A, 1 gives it to B
    logic                  turn;

    function automatic logic [`ROB_SEQ_W-1:0] popcnt(input logic [`ROB_CELLS-1:0] vec);
        logic [`ROB_SEQ_W-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < `ROB_CELLS; i++) begin
            cnt = cnt + {{(`ROB_SEQ_W-1){1'b0}}, vec[i]};
        end
        return cnt;
    endfunction

    assign free = ~i_cell_valid;

    // A fills from the bottom
    always_comb begin
        low_free = '0;
        for (int i = `ROB_CELLS - 1; i >= 0; i--) begin
            if (free[i]) begin
                low_free    = '0;
                low_free[i] = 1'b1;
            end
        end
    end

    // B fills from the top
    always_comb begin
        high_free = '0;
        for (int i = 0; i < `ROB_CELLS; i++) begin
            if (free[i]) begin
                high_free    = '0;
                high_free[i] = 1'b1;
            end
        end
    end

    assign free_cnt  = popcnt(free);
    assign one_free  = (free_cnt == `ROB_SEQ_W'(1));
    assign many_free = (free_cnt > `ROB_SEQ_W'(1));

    assign o_ready_a = many_free | (one_free & ~turn);
    assign o_ready_b = many_free | (one_free & turn);

    assign o_load_a = low_free & {`ROB_CELLS{i_accept_a}};
    assign o_load_b = high_free & {`ROB_CELLS{i_accept_b}};

    // older flits of the same id still held after this edge
    assign o_seq_a = popcnt(i_match_a);
    assign o_seq_b = popcnt(i_match_b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            turn <= 1'b0;
        end else if (one_free && (i_accept_a || i_accept_b)) begin
            turn <= ~turn;
        end
    end

    a_load_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
        (o_load_a & o_load_b) == '0);

endmodule

// ==== design/ordering_cell.sv ====
`include "rob_defines.svh"

module ordering_cell (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_load_a,
    input  logic                      i_load_b,
    input  rob_pkg::flit_id_u         i_id_a,
    input  rob_pkg::flit_id_u         i_id_b,
    input  logic [`ROB_QOS_W-1:0]     i_qos_a,
    input  logic [`ROB_QOS_W-1:0]     i_qos_b,
    input  logic [`ROB_PAYLOAD_W-1:0] i_payload_a,
    input  logic [`ROB_PAYLOAD_W-1:0] i_payload_b,
    input  logic [`ROB_SEQ_W-1:0]     i_seq_a,
    input  logic [`ROB_SEQ_W-1:0]     i_seq_b,
    input  logic                      i_retire,
    input  logic                      i_retire_en,
    input  rob_pkg::flit_id_u         i_retire_id,
    output logic                      o_valid,
    output logic                      o_head,
    output logic [`ROB_QOS_W-1:0]     o_qos,
    output rob_pkg::flit_id_u         o_id,
    output logic [`ROB_PAYLOAD_W-1:0] o_payload,
    output logic                      o_match_a,
    output logic                      o_match_b
);

    import rob_pkg::*;

    logic                      valid_q;
    flit_id_u                  id_q;
    logic [`ROB_QOS_W-1:0]     qos_q;
    logic [`ROB_PAYLOAD_W-1:0] payload_q;
    // number of older flits with the same id
    logic [`ROB_SEQ_W-1:0]     seq_q;
    logic                      load;
    logic                      peer_retire;

    assign load = i_load_a | i_load_b;

    // an older flit of this id leaves from another cell
    assign peer_retire = i_retire_en & ~i_retire & valid_q &
                         (id_q.raw == i_retire_id.raw);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            seq_q   <= '0;
        end else if (load) begin
            valid_q <= 1'b1;
            seq_q   <= i_load_b ? i_seq_b : i_seq_a;
        end else begin
            if (i_retire) begin
                valid_q <= 1'b0;
            end
            if (peer_retire && (seq_q != '0)) begin
                seq_q <= seq_q - `ROB_SEQ_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            id_q      <= i_load_b ? i_id_b : i_id_a;
            qos_q     <= i_load_b ? i_qos_b : i_qos_a;
            payload_q <= i_load_b ? i_payload_b : i_payload_a;
        end
    end

    assign o_valid   = valid_q;
    assign o_head    = valid_q & (seq_q == '0);
    assign o_qos     = qos_q;
    assign o_id      = id_q;
    assign o_payload = payload_q;

    // a cell leaving this cycle no longer counts as older
    assign o_match_a = valid_q & ~i_retire & (id_q.raw == i_id_a.raw);
    assign o_match_b = valid_q & ~i_retire & (id_q.raw == i_id_b.raw);

    a_no_load_valid: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> !valid_q);

    a_single_port_load: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_load_a && i_load_b));

endmodule

// ==== design/qos_arbiter.sv ====
`include "rob_defines.svh"

module qos_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`ROB_CELLS-1:0]     i_head,
    input  logic [`ROB_QOS_W-1:0]     i_qos [`ROB_CELLS],
    input  rob_pkg::flit_id_u         i_id [`ROB_CELLS],
    input  logic [`ROB_PAYLOAD_W-1:0] i_payload [`ROB_CELLS],
    input  logic                      i_ready_c,
    output logic [`ROB_CELLS-1:0]     o_retire,
    output rob_pkg::flit_id_u         o_retire_id,
    output logic                      o_valid_c,
    output logic [`ROB_SRC_W:0]       o_id_c,
    output logic [`ROB_QOS_W-1:0]     o_qos_c,
    output logic [`ROB_PAYLOAD_W-1:0] o_payload_c
);

    import rob_pkg::*;

    logic [`ROB_QOS_W-1:0]     best_qos;
    logic [`ROB_CELLS-1:0]     sel;
    flit_id_u                  sel_id;
    logic [`ROB_PAYLOAD_W-1:0] sel_payload;
    logic                      any_head;
    logic                      load_out;

    // highest qos among the heads
    always_comb begin
        best_qos = '0;
        for (int i = 0; i < `ROB_CELLS; i++) begin
            if (i_head[i] && (i_qos[i] > best_qos)) begin
                best_qos = i_qos[i];
            end
        end
    end

    // lowest index wins a tie
    always_comb begin
        sel = '0;
        for (int i = `ROB_CELLS - 1; i >= 0; i--) begin
            if (i_head[i] && (i_qos[i] == best_qos)) begin
                sel    = '0;
                sel[i] = 1'b1;
            end
        end
    end

    // and-or mux over the one-hot select
    always_comb begin
        sel_id.raw  = '0;
        sel_payload = '0;
        for (int i = 0; i < `ROB_CELLS; i++) begin
            sel_id.raw  = sel_id.raw | ({(`ROB_SRC_W+1){sel[i]}} & i_id[i].raw);
            sel_payload = sel_payload | ({`ROB_PAYLOAD_W{sel[i]}} & i_payload[i]);
        end
    end

    assign any_head = |i_head;
    // output register empty or being taken this cycle
    assign load_out = any_head & (~o_valid_c | i_ready_c);

    assign o_retire    = sel & {`ROB_CELLS{load_out}};
    assign o_retire_id = sel_id;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid_c   <= 1'b0;
            o_id_c      <= '0;
            o_qos_c     <= '0;
            o_payload_c <= '0;
        end else if (load_out) begin
            o_valid_c   <= 1'b1;
            o_id_c      <= sel_id.raw;
            o_qos_c     <= best_qos;
            o_payload_c <= sel_payload;
        end else if (i_ready_c) begin
            o_valid_c   <= 1'b0;
        end
    end

    // a stalled flit on port C stays put until it is taken
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (o_valid_c && !i_ready_c) |=>
        (o_valid_c && $stable(o_id_c) && $stable(o_qos_c) && $stable(o_payload_c)));

endmodule

// ==== design/reorder_buffer.sv ====
`include "rob_defines.svh"

module reorder_buffer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_valid_a,
    input  logic [`ROB_SRC_W-1:0]     i_src_a,
    input  logic [`ROB_QOS_W-1:0]     i_qos_a,
    input  logic [`ROB_PAYLOAD_W-1:0] i_payload_a,
    output logic                      o_ready_a,
    input  logic                      i_valid_b,
    input  logic [`ROB_SRC_W-1:0]     i_src_b,
    input  logic [`ROB_QOS_W-1:0]     i_qos_b,
    input  logic [`ROB_PAYLOAD_W-1:0] i_payload_b,
    output logic                      o_ready_b,
    output logic                      o_valid_c,
    input  logic                      i_ready_c,
    output logic [`ROB_SRC_W:0]       o_id_c,
    output logic [`ROB_QOS_W-1:0]     o_qos_c,
    output logic [`ROB_PAYLOAD_W-1:0] o_payload_c
);

    import rob_pkg::*;

    flit_id_u                  id_a;
    flit_id_u                  id_b;
    logic                      accept_a;
    logic                      accept_b;
    logic [`ROB_CELLS-1:0]     load_a;
    logic [`ROB_CELLS-1:0]     load_b;
    logic [`ROB_SEQ_W-1:0]     seq_a;
    logic [`ROB_SEQ_W-1:0]     seq_b;
    logic [`ROB_CELLS-1:0]     cell_valid;
    logic [`ROB_CELLS-1:0]     cell_head;
    logic [`ROB_CELLS-1:0]     match_a;
    logic [`ROB_CELLS-1:0]     match_b;
    logic [`ROB_QOS_W-1:0]     cell_qos [`ROB_CELLS];
    flit_id_u                  cell_id [`ROB_CELLS];
    logic [`ROB_PAYLOAD_W-1:0] cell_payload [`ROB_CELLS];
    logic [`ROB_CELLS-1:0]     retire;
    logic                      retire_any;
    flit_id_u                  retire_id;

    // port bit tells the same source id on A and B apart
    assign id_a.fields = flit_id_fields_t'{port: 1'b0, src: i_src_a};
    assign id_b.fields = flit_id_fields_t'{port: 1'b1, src: i_src_b};

    assign accept_a   = i_valid_a & o_ready_a;
    assign accept_b   = i_valid_b & o_ready_b;
    assign retire_any = |retire;

    slot_allocator u_alloc (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_cell_valid (cell_valid),
        .i_match_a    (match_a),
        .i_match_b    (match_b),
        .i_accept_a   (accept_a),
        .i_accept_b   (accept_b),
        .o_ready_a    (o_ready_a),
        .o_ready_b    (o_ready_b),
        .o_load_a     (load_a),
        .o_load_b     (load_b),
        .o_seq_a      (seq_a),
        .o_seq_b      (seq_b)
    );

    for (genvar g = 0; g < `ROB_CELLS; g++) begin : g_cell
        ordering_cell u_cell (
            .clk         (clk),
            .rst_n       (rst_n),
            .i_load_a    (load_a[g]),
            .i_load_b    (load_b[g]),
            .i_id_a      (id_a),
            .i_id_b      (id_b),
            .i_qos_a     (i_qos_a),
            .i_qos_b     (i_qos_b),
            .i_payload_a (i_payload_a),
            .i_payload_b (i_payload_b),
            .i_seq_a     (seq_a),
            .i_seq_b     (seq_b),
            .i_retire    (retire[g]),
            .i_retire_en (retire_any),
            .i_retire_id (retire_id),
            .o_valid     (cell_valid[g]),
            .o_head      (cell_head[g]),
            .o_qos       (cell_qos[g]),
            .o_id        (cell_id[g]),
            .o_payload   (cell_payload[g]),
            .o_match_a   (match_a[g]),
            .o_match_b   (match_b[g])
        );
    end

    qos_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_head      (cell_head),
        .i_qos       (cell_qos),
        .i_id        (cell_id),
        .i_payload   (cell_payload),
        .i_ready_c   (i_ready_c),
        .o_retire    (retire),
        .o_retire_id (retire_id),
        .o_valid_c   (o_valid_c),
        .o_id_c      (o_id_c),
        .o_qos_c     (o_qos_c),
        .o_payload_c (o_payload_c)
    );

endmodule

// ==== tests/rob_model.svh ====
// per cell: valid, flit id, qos, payload and count of older flits of the same id
logic                      m_valid   [`ROB_CELLS];
logic [`ROB_SRC_W:0]       m_id      [`ROB_CELLS];
logic [`ROB_QOS_W-1:0]     m_qos     [`ROB_CELLS];
logic [`ROB_PAYLOAD_W-1:0] m_payload [`ROB_CELLS];
int                        m_seq     [`ROB_CELLS];
// turn 0 means port A gets the last free cell
logic                      m_turn;
logic                      m_out_valid;
logic [`ROB_SRC_W:0]       m_out_id;
logic [`ROB_QOS_W-1:0]     m_out_qos;
logic [`ROB_PAYLOAD_W-1:0] m_out_payload;

function automatic int free_cells();
    int n;
    n = 0;
    for (int i = 0; i < `ROB_CELLS; i++) begin
        if (!m_valid[i]) begin
            n++;
        end
    end
    return n;
endfunction

function automatic logic ready_for_a();
    return (free_cells() > 1) || ((free_cells() == 1) && !m_turn);
endfunction

function automatic logic ready_for_b();
    return (free_cells() > 1) || ((free_cells() == 1) && m_turn);
endfunction

task automatic reset_model();
    for (int i = 0; i < `ROB_CELLS; i++) begin
        m_valid[i] = 1'b0;
        m_seq[i]   = 0;
    end
    m_turn      = 1'b0;
    m_out_valid = 1'b0;
endtask

// one rising edge, with the inputs seen before the edge
task automatic step_model(input logic va, input logic [`ROB_SRC_W-1:0] sa,
                          input logic [`ROB_QOS_W-1:0] qa, input logic [`ROB_PAYLOAD_W-1:0] pa,
                          input logic vb, input logic [`ROB_SRC_W-1:0] sb,
                          input logic [`ROB_QOS_W-1:0] qb, input logic [`ROB_PAYLOAD_W-1:0] pb,
                          input logic ready_c);
    int                  free;
    int                  slot_a;
    int                  slot_b;
    int                  win;
    int                  seq_a;
    int                  seq_b;
    logic                acc_a;
    logic                acc_b;
    logic                take;
    logic [`ROB_SRC_W:0] id_a;
    logic [`ROB_SRC_W:0] id_b;
    free   = free_cells();
    acc_a  = va && ready_for_a();
    acc_b  = vb && ready_for_b();
    id_a   = {1'b0, sa};
    id_b   = {1'b1, sb};
    slot_a = -1;
    slot_b = -1;
    // A takes the lowest free cell, B the highest
    for (int i = `ROB_CELLS - 1; i >= 0; i--) begin
        if (!m_valid[i]) begin
            slot_a = i;
        end
    end
    for (int i = 0; i < `ROB_CELLS; i++) begin
        if (!m_valid[i]) begin
            slot_b = i;
        end
    end
    // oldest flit of each id, highest qos, lowest index on a tie
    win = -1;
    for (int i = 0; i < `ROB_CELLS; i++) begin
        if (m_valid[i] && (m_seq[i] == 0)) begin
            if ((win < 0) || (m_qos[i] > m_qos[win])) begin
                win = i;
            end
        end
    end
    take = (win >= 0) && (!m_out_valid || ready_c);
    // older flits of the same id still held after this edge
    seq_a = 0;
    seq_b = 0;
    for (int i = 0; i < `ROB_CELLS; i++) begin
        if (m_valid[i] && !(take && (i == win))) begin
            if (m_id[i] == id_a) begin
                seq_a++;
            end
            if (m_id[i] == id_b) begin
                seq_b++;
            end
        end
    end
    if (take) begin
        m_out_valid   = 1'b1;
        m_out_id      = m_id[win];
        m_out_qos     = m_qos[win];
        m_out_payload = m_payload[win];
        for (int i = 0; i < `ROB_CELLS; i++) begin
            if ((i != win) && m_valid[i] && (m_id[i] == m_id[win]) && (m_seq[i] > 0)) begin
                m_seq[i]--;
            end
        end
        m_valid[win] = 1'b0;
    end else if (ready_c) begin
        m_out_valid = 1'b0;
    end
    if (acc_a) begin
        m_valid[slot_a]   = 1'b1;
        m_id[slot_a]      = id_a;
        m_qos[slot_a]     = qa;
        m_payload[slot_a] = pa;
        m_seq[slot_a]     = seq_a;
    end
    if (acc_b) begin
        m_valid[slot_b]   = 1'b1;
        m_id[slot_b]      = id_b;
        m_qos[slot_b]     = qb;
        m_payload[slot_b] = pb;
        m_seq[slot_b]     = seq_b;
    end
    if ((free == 1) && (acc_a || acc_b)) begin
        m_turn = !m_turn;
    end
endtask

// ==== tests/tb_reorder_buffer.sv ====
`include "rob_defines.svh"

module tb_reorder_buffer;

    localparam int CW = `ROB_PAYLOAD_W;

    logic                      clk;
    logic                      rst_n;
    logic                      i_valid_a;
    logic [`ROB_SRC_W-1:0]     i_src_a;
    logic [`ROB_QOS_W-1:0]     i_qos_a;
    logic [`ROB_PAYLOAD_W-1:0] i_payload_a;
    logic                      o_ready_a;
    logic                      i_valid_b;
    logic [`ROB_SRC_W-1:0]     i_src_b;
    logic [`ROB_QOS_W-1:0]     i_qos_b;
    logic [`ROB_PAYLOAD_W-1:0] i_payload_b;
    logic                      o_ready_b;
    logic                      o_valid_c;
    logic                      i_ready_c;
    logic [`ROB_SRC_W:0]       o_id_c;
    logic [`ROB_QOS_W-1:0]     o_qos_c;
    logic [`ROB_PAYLOAD_W-1:0] o_payload_c;

    int                    errors;
    int                    test_errors;
    int                    tests_run;
    int                    tests_failed;
    int                    acc_count;
    int                    out_count;
    int                    turn_handoffs;
    int                    last_turn_port;
    int                    qos_drain_idx;
    logic [`ROB_QOS_W-1:0] prev_qos;
    logic [31:0]           rng_state;
    logic [31:0]           serial;
    logic [31:0]           last_serial [64];
    logic [`ROB_SRC_W-1:0] src_cnt;
    logic                  a_taken;
    logic                  b_taken;

    `include "rob_model.svh"

    reorder_buffer uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid_a   (i_valid_a),
        .i_src_a     (i_src_a),
        .i_qos_a     (i_qos_a),
        .i_payload_a (i_payload_a),
        .o_ready_a   (o_ready_a),
        .i_valid_b   (i_valid_b),
        .i_src_b     (i_src_b),
        .i_qos_b     (i_qos_b),
        .i_payload_b (i_payload_b),
        .o_ready_b   (o_ready_b),
        .o_valid_c   (o_valid_c),
        .i_ready_c   (i_ready_c),
        .o_id_c      (o_id_c),
        .o_qos_c     (o_qos_c),
        .o_payload_c (o_payload_c)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // low word carries an arrival serial for the order check
    function automatic logic [CW-1:0] next_payload();
        logic [CW-1:0] p;
        p = {xorshift(), xorshift(), xorshift(), serial};
        serial = serial + 32'd1;
        return p;
    endfunction

    task automatic check_value(input string what, input logic [CW-1:0] got,
                               input logic [CW-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout while waiting for %s", what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // a new flit replaces the old one only once it was taken
    task automatic drive_inputs(input int valid_pct, input logic uniq);
        logic [31:0] r;
        if (!i_valid_a || a_taken) begin
            r = xorshift();
            i_valid_a   <= (r % 100) < valid_pct;
            i_src_a     <= uniq ? src_cnt : {2'b00, r[10:8]};
            i_qos_a     <= r[13:12];
            i_payload_a <= next_payload();
            src_cnt     = src_cnt + 5'd1;
        end
        if (!i_valid_b || b_taken) begin
            r = xorshift();
            i_valid_b   <= (r % 100) < valid_pct;
            i_src_b     <= uniq ? src_cnt : {2'b00, r[10:8]};
            i_qos_b     <= r[13:12];
            i_payload_b <= next_payload();
            src_cnt     = src_cnt + 5'd1;
        end
    endtask

    task automatic wait_full(input string what, input logic uniq);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (!o_ready_a && !o_ready_b) begin
                done = 1'b1;
            end else if (n >= 100) begin
                timeout_abort(what);
            end else begin
                n++;
                @(posedge clk);
                drive_inputs(100, uniq);
            end
        end
    endtask

    task automatic drain_buffer(input string what);
        int   n;
        logic done;
        @(posedge clk);
        i_valid_a <= 1'b0;
        i_valid_b <= 1'b0;
        i_ready_c <= 1'b1;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (!o_valid_c && (free_cells() == `ROB_CELLS)) begin
                done = 1'b1;
            end else if (n >= 100) begin
                timeout_abort(what);
            end else begin
                n++;
            end
        end
    endtask

    task automatic record_departure();
        check_value("id order", CW'(o_payload_c[31:0] > last_serial[o_id_c]), CW'(1));
        last_serial[o_id_c] = o_payload_c[31:0];
        out_count++;
        if (qos_drain_idx >= 0) begin
            // first one was loaded before the rest arrived
            if (qos_drain_idx >= 2) begin
                check_value("qos order", CW'(o_qos_c <= prev_qos), CW'(1));
            end
            prev_qos = o_qos_c;
            qos_drain_idx++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            step_model(i_valid_a, i_src_a, i_qos_a, i_payload_a,
                       i_valid_b, i_src_b, i_qos_b, i_payload_b, i_ready_c);
        end
    end

    // compare in the middle of the cycle where everything is settled
    always @(negedge clk) begin
        check_value("ready a", CW'(o_ready_a), CW'(ready_for_a()));
        check_value("ready b", CW'(o_ready_b), CW'(ready_for_b()));
        check_value("valid c", CW'(o_valid_c), CW'(m_out_valid));
        if (m_out_valid) begin
            check_value("id c", CW'(o_id_c), CW'(m_out_id));
            check_value("qos c", CW'(o_qos_c), CW'(m_out_qos));
            check_value("payload c", o_payload_c, m_out_payload);
        end
        a_taken = i_valid_a && o_ready_a;
        b_taken = i_valid_b && o_ready_b;
        if (rst_n) begin
            acc_count = acc_count + int'(a_taken) + int'(b_taken);
            if (free_cells() == 1) begin
                check_value("single ready", CW'(o_ready_a ^ o_ready_b), CW'(1));
                if (a_taken || b_taken) begin
                    if (last_turn_port >= 0) begin
                        check_value("turn alternates",
                                    CW'(int'(b_taken) != last_turn_port), CW'(1));
                    end
                    last_turn_port = int'(b_taken);
                    turn_handoffs++;
                end
            end
            if (free_cells() == 0) begin
                check_value("full ready", CW'({o_ready_a, o_ready_b}), CW'(0));
            end
            if (o_valid_c && i_ready_c) begin
                record_departure();
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          handoffs_start;
        clk            = 1'b0;
        rst_n         <= 1'b0;
        i_valid_a     <= 1'b0;
        i_src_a       <= '0;
        i_qos_a       <= '0;
        i_payload_a   <= '0;
        i_valid_b     <= 1'b0;
        i_src_b       <= '0;
        i_qos_b       <= '0;
        i_payload_b   <= '0;
        i_ready_c     <= 1'b0;
        rng_state      = 32'h5a72;
        serial         = 32'd1;
        src_cnt        = '0;
        a_taken        = 1'b0;
        b_taken        = 1'b0;
        errors         = 0;
        test_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        acc_count      = 0;
        out_count      = 0;
        turn_handoffs  = 0;
        last_turn_port = -1;
        qos_drain_idx  = -1;
        prev_qos       = '0;
        for (int k = 0; k < 64; k++) begin
            last_serial[k] = '0;
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset valid c", CW'(o_valid_c), CW'(0));
        check_value("reset ready a", CW'(o_ready_a), CW'(1));
        check_value("reset ready b", CW'(o_ready_b), CW'(1));
        finish_test("reset state");

        // few source ids so that ids repeat often
        for (int c = 0; c < 400; c++) begin
            @(posedge clk);
            drive_inputs(60, 1'b0);
            r = xorshift();
            i_ready_c <= r[0] | r[1];
        end
        drain_buffer("random traffic drain");
        finish_test("random traffic");

        // distinct ids, so every held flit is a head
        qos_drain_idx = 0;
        @(posedge clk);
        i_ready_c <= 1'b0;
        drive_inputs(100, 1'b1);
        wait_full("qos fill", 1'b1);
        drain_buffer("qos drain");
        qos_drain_idx = -1;
        finish_test("qos drain order");

        handoffs_start = turn_handoffs;
        @(posedge clk);
        i_ready_c <= 1'b0;
        drive_inputs(100, 1'b0);
        wait_full("fill with both ports", 1'b0);
        for (int p = 0; p < 4; p++) begin
            @(posedge clk);
            drive_inputs(100, 1'b0);
            i_ready_c <= 1'b1;
            @(posedge clk);
            drive_inputs(100, 1'b0);
            i_ready_c <= 1'b0;
            wait_full("refill after one flit out", 1'b0);
        end
        check_value("turn handoffs", CW'(turn_handoffs - handoffs_start >= 5), CW'(1));
        finish_test("last cell turn");

        // drain wait fails on a timeout unless o_valid_c falls
        drain_buffer("final drain");
        check_value("flits out vs in", CW'(out_count), CW'(acc_count));
        finish_test("final drain");

        $display("tests run %0d, tests failed %0d, mismatches %0d, flits %0d",
                 tests_run, tests_failed, errors, out_count);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== reorder_buffer.f ====
+incdir+design
+incdir+tests
design/rob_pkg.sv
design/slot_allocator.sv
design/ordering_cell.sv
design/qos_arbiter.sv
design/reorder_buffer.sv
tests/tb_reorder_buffer.sv

// ==== Makefile ====
TOP := tb_reorder_buffer

.PHONY: lint sim clean

lint:
	verilator --lint-only -sv --timing --assert -f reorder_buffer.f --top-module $(TOP)

sim:
	verilator --binary -sv --timing --assert -f reorder_buffer.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
